// File: common/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // parity bit mode, fixed per build
    typedef enum logic [1:0] {
        parity_none,
        parity_even,
        parity_odd
    } parity_e;

    // bit periods in one frame
    function automatic int frame_bits(
        input int      start,
        input int      data,
        input parity_e parity,
        input int      stop
    );
        int total;
        total = start + data + stop;
        if (parity != parity_none) begin
            total = total + 1;
        end
        return total;
    endfunction

endpackage

`default_nettype wire

// File: logic/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLKFREQ  = 100_000_000,
    parameter int TICKFREQ = 1_843_200
) (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    // sum of the two rates always fits, acc stays below CLKFREQ
    localparam int ACC_W = $clog2(CLKFREQ + TICKFREQ + 1);

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_sum;

    assign acc_sum = acc + ACC_W'(TICKFREQ);

    // preload so the first overflow is one add away
    always_ff @(posedge clk) begin
        if (rst) begin
            acc  <= ACC_W'(CLKFREQ - TICKFREQ);
            tick <= 1'b0;
        end else if (acc_sum >= ACC_W'(CLKFREQ)) begin
            // remainder carries over, so fractional ratios average out
            acc  <= acc_sum - ACC_W'(CLKFREQ);
            tick <= 1'b1;
        end else begin
            acc  <= acc_sum;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              push,
    input  wire  [WIDTH-1:0] wr_data,
    output logic             full,
    input  wire              pop,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // first word falls through
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart_tx/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
    parameter int      START      = 1,
    parameter int      STOP       = 1,
    parameter int      DATA       = 8,
    parameter parity_e PARITY     = parity_none,
    parameter int      OVERSAMPLE = 16
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             tick,
    output logic            tx,
    output logic            tx_en,
    input  wire             valid,
    input  wire  [DATA-1:0] data,
    output logic            ready
);

    localparam int FRAME_BITS = frame_bits(START, DATA, PARITY, STOP);
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam int TICK_W     = (OVERSAMPLE > 1) ? $clog2(OVERSAMPLE) : 1;
    localparam int PAR_IDX    = START + DATA;

    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(FRAME_BITS - 1);

    logic                  busy;
    logic [TICK_W-1:0]     tick_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] frame_sr;
    logic [FRAME_BITS-1:0] frame_load;
    logic                  bit_end;

    // start bits low, data lsb first, then parity and stop bits
    always_comb begin
        frame_load = '1;
        frame_load[START-1:0] = '0;
        frame_load[START +: DATA] = data;
        if (PARITY != parity_none) begin
            frame_load[PAR_IDX] = ^data ^ (PARITY == parity_odd);
        end
    end

    assign ready   = !busy;
    assign bit_end = tx_en && tick && (tick_cnt == LAST_TICK);

    // line idles high whenever the frame is not on the wire
    assign tx = !tx_en || frame_sr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            tx_en    <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (valid) begin
                busy <= 1'b1;
            end
        end else if (tick) begin
            if (!tx_en) begin
                // word accepted, start bit begins on this tick
                tx_en    <= 1'b1;
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end else if (tick_cnt == LAST_TICK) begin
                tick_cnt <= '0;
                if (bit_cnt == LAST_BIT) begin
                    busy  <= 1'b0;
                    tx_en <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready && valid) begin
            frame_sr <= frame_load;
        end else if (bit_end) begin
            frame_sr <= {1'b1, frame_sr[FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: uart_rx/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
    parameter int      START      = 1,
    parameter int      STOP       = 1,
    parameter int      DATA       = 8,
    parameter parity_e PARITY     = parity_none,
    parameter int      OVERSAMPLE = 16
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             tick,
    input  wire             rx,
    input  wire             rx_mask,
    output logic            valid,
    output logic [DATA-1:0] data,
    output logic            frame_error,
    output logic            parity_error
);

    localparam int FRAME_BITS = frame_bits(START, DATA, PARITY, STOP);
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam int TICK_W     = (OVERSAMPLE > 1) ? $clog2(OVERSAMPLE) : 1;

    localparam logic [TICK_W-1:0] MID_TICK   = TICK_W'(OVERSAMPLE / 2);
    localparam logic [TICK_W-1:0] LAST_TICK  = TICK_W'(OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  DATA_FIRST = BIT_W'(START);
    localparam logic [BIT_W-1:0]  PAR_IDX    = BIT_W'(START + DATA);
    localparam logic [BIT_W-1:0]  STOP_FIRST = BIT_W'(FRAME_BITS - STOP);
    localparam logic [BIT_W-1:0]  LAST_BIT   = BIT_W'(FRAME_BITS - 1);

    logic              rx_meta;
    logic              rx_sync;
    logic              active;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic              sample_now;
    logic              par_bit;
    logic              stop_err;
    logic              data_xor;

    assign sample_now = active && tick && (tick_cnt == MID_TICK);
    assign data_xor   = ^data;

    // two-flop synchronizer, idle level is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || rx_mask) begin
            active   <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (!active) begin
                if (!rx_sync) begin
                    active   <= 1'b1;
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (tick) begin
                if (tick_cnt == LAST_TICK) begin
                    tick_cnt <= '0;
                    bit_cnt  <= bit_cnt + 1'b1;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
                if (sample_now) begin
                    // glitch, not a real start bit
                    if (bit_cnt < DATA_FIRST && rx_sync) begin
                        active <= 1'b0;
                    end
                    // done at the stop mid sample, free to hunt again
                    if (bit_cnt == LAST_BIT) begin
                        active <= 1'b0;
                        valid  <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active) begin
            stop_err <= 1'b0;
        end
        if (sample_now) begin
            if (bit_cnt >= DATA_FIRST && bit_cnt < PAR_IDX) begin
                data <= {rx_sync, data[DATA-1:1]};
            end
            if (PARITY != parity_none && bit_cnt == PAR_IDX) begin
                par_bit <= rx_sync;
            end
            if (bit_cnt >= STOP_FIRST) begin
                stop_err <= stop_err || !rx_sync;
            end
            if (bit_cnt == LAST_BIT) begin
                frame_error  <= stop_err || !rx_sync;
                parity_error <= (PARITY != parity_none) &&
                                (data_xor ^ par_bit ^ (PARITY == parity_odd));
            end
        end
    end

endmodule

`default_nettype wire

// File: uart_core/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core import uart_pkg::*; #(
    parameter int      START      = 1,
    parameter int      STOP       = 1,
    parameter int      DATA       = 8,
    parameter parity_e PARITY     = parity_none,
    parameter int      CLKFREQ    = 100_000_000,
    parameter int      BAUD       = 115_200,
    parameter int      FIFO_DEPTH = 1,
    parameter int      OVERSAMPLE = 16
) (
    input  wire             clk,
    input  wire             rst,
    output logic            tx,
    input  wire             rx,
    output logic            tx_en,
    input  wire             rx_mask,
    input  wire             tx_push,
    input  wire  [DATA-1:0] tx_data,
    output logic            tx_full,
    input  wire             rx_pop,
    output logic [DATA-1:0] rx_data,
    output logic            rx_empty,
    input  wire             error_clear,
    output logic            error_frame,
    output logic            error_parity
);

    logic            tick;
    logic            txi_ready;
    logic            txi_valid;
    logic [DATA-1:0] txi_data;
    logic            rxi_valid;
    logic [DATA-1:0] rxi_data;
    logic            rxi_frame_error;
    logic            rxi_parity_error;
    logic            rxi_good;

    baud_tick_gen #(
        .CLKFREQ  (CLKFREQ),
        .TICKFREQ (BAUD * OVERSAMPLE)
    ) u_baud_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_tx #(
        .START      (START),
        .STOP       (STOP),
        .DATA       (DATA),
        .PARITY     (PARITY),
        .OVERSAMPLE (OVERSAMPLE)
    ) u_uart_tx (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .tx    (tx),
        .tx_en (tx_en),
        .valid (txi_valid),
        .data  (txi_data),
        .ready (txi_ready)
    );

    // one stop bit is enough on the receive side
    uart_rx #(
        .START      (START),
        .STOP       (1),
        .DATA       (DATA),
        .PARITY     (PARITY),
        .OVERSAMPLE (OVERSAMPLE)
    ) u_uart_rx (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .rx           (rx),
        .rx_mask      (rx_mask),
        .valid        (rxi_valid),
        .data         (rxi_data),
        .frame_error  (rxi_frame_error),
        .parity_error (rxi_parity_error)
    );

    assign rxi_good = rxi_valid && !rxi_frame_error && !rxi_parity_error;

    // sticky flags, a new error beats a same-cycle clear
    always_ff @(posedge clk) begin
        if (rst) begin
            error_frame  <= 1'b0;
            error_parity <= 1'b0;
        end else begin
            if (error_clear) begin
                error_frame  <= 1'b0;
                error_parity <= 1'b0;
            end
            if (rxi_valid && rxi_frame_error) begin
                error_frame <= 1'b1;
            end
            if (rxi_valid && rxi_parity_error) begin
                error_parity <= 1'b1;
            end
        end
    end

    if (FIFO_DEPTH <= 1) begin : gen_no_fifo
        logic [DATA-1:0] rx_hold;

        assign txi_valid = tx_push;
        assign txi_data  = tx_data;
        assign tx_full   = !txi_ready;
        assign rx_data   = rx_hold;

        // single-word holding register, new words dropped while occupied
        always_ff @(posedge clk) begin
            if (rst) begin
                rx_empty <= 1'b1;
            end else if (rxi_good && (rx_empty || rx_pop)) begin
                rx_empty <= 1'b0;
            end else if (rx_pop) begin
                rx_empty <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rxi_good && (rx_empty || rx_pop)) begin
                rx_hold <= rxi_data;
            end
        end
    end else begin : gen_fifo
        logic tx_fifo_empty;
        logic rx_fifo_full;

        assign txi_valid = !tx_fifo_empty;

        sync_fifo #(
            .WIDTH (DATA),
            .DEPTH (FIFO_DEPTH)
        ) u_tx_fifo (
            .clk     (clk),
            .rst     (rst),
            .push    (tx_push),
            .wr_data (tx_data),
            .full    (tx_full),
            .pop     (txi_valid && txi_ready),
            .rd_data (txi_data),
            .empty   (tx_fifo_empty)
        );

        sync_fifo #(
            .WIDTH (DATA),
            .DEPTH (FIFO_DEPTH)
        ) u_rx_fifo (
            .clk     (clk),
            .rst     (rst),
            .push    (rxi_good && !rx_fifo_full),
            .wr_data (rxi_data),
            .full    (rx_fifo_full),
            .pop     (rx_pop),
            .rd_data (rx_data),
            .empty   (rx_empty)
        );
    end

endmodule

`default_nettype wire

// File: tb/uart_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core_properties (
    input wire clk,
    input wire rst,
    input wire tx,
    input wire tx_en,
    input wire tx_full,
    input wire rx_empty,
    input wire rx_valid,
    input wire error_clear,
    input wire error_frame,
    input wire error_parity
);

    int assert_failures = 0;

    // start bit is on the line as tx_en rises
    start_low: assert property (@(posedge clk) disable iff (rst) $rose(tx_en) |-> !tx)
        else begin
            assert_failures++;
            $error("tx not low for the start bit when tx_en rose");
        end

    reset_state: assert property (@(posedge clk)
        rst |=> (!tx_full && rx_empty && tx && !tx_en && !error_frame && !error_parity))
        else begin
            assert_failures++;
            $error("outputs not at their reset values during reset");
        end

    // flags only follow a receiver report
    frame_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(error_frame) |-> $past(rx_valid))
        else begin
            assert_failures++;
            $error("error_frame rose without an rx valid pulse");
        end

    parity_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(error_parity) |-> $past(rx_valid))
        else begin
            assert_failures++;
            $error("error_parity rose without an rx valid pulse");
        end

    frame_sticky: assert property (@(posedge clk) disable iff (rst)
        error_frame && !error_clear |=> error_frame)
        else begin
            assert_failures++;
            $error("error_frame fell without error_clear");
        end

endmodule

bind uart_core uart_core_properties u_uart_core_properties (
    .clk          (clk),
    .rst          (rst),
    .tx           (tx),
    .tx_en        (tx_en),
    .tx_full      (tx_full),
    .rx_empty     (rx_empty),
    .rx_valid     (rxi_valid),
    .error_clear  (error_clear),
    .error_frame  (error_frame),
    .error_parity (error_parity)
);

`default_nettype wire

// File: tb/tb_uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_core
    import uart_pkg::*;
();

    localparam int      START        = 1;
    localparam int      STOP         = 1;
    localparam int      DATA         = 8;
    localparam parity_e PARITY       = parity_even;
    localparam int      CLKFREQ      = 1_600_000;
    localparam int      BAUD         = 100_000;
    localparam int      OVERSAMPLE   = 16;
    localparam int      FIFO_DEPTH   = 4;
    localparam int      RESET_CYCLES = 16;
    localparam int      FRAME_BITS   = frame_bits(START, DATA, PARITY, STOP);
    localparam int      TIMEOUT      = RESET_CYCLES + 40 * FRAME_BITS * OVERSAMPLE;

    logic            clk;
    logic            rst;
    logic            tx;
    logic            rx;
    logic            tx_en;
    logic            rx_mask;
    logic            tx_push;
    logic [DATA-1:0] tx_data;
    logic            tx_full;
    logic            rx_pop;
    logic [DATA-1:0] rx_data;
    logic            rx_empty;
    logic            error_clear;
    logic            error_frame;
    logic            error_parity;
    logic            loopback;
    logic            forced_rx;
    logic [31:0]     rng_state;
    logic            tx_en_q = 1'b0;
    int              tx_en_rises = 0;
    int              tests = 0;
    int              checks = 0;
    int              failures = 0;
    int              failures_before = 0;
    logic [DATA-1:0] expected [$];

    // rx comes from our own tx or from the frame shaper
    assign rx = loopback ? tx : forced_rx;

    uart_core #(
        .START      (START),
        .STOP       (STOP),
        .DATA       (DATA),
        .PARITY     (PARITY),
        .CLKFREQ    (CLKFREQ),
        .BAUD       (BAUD),
        .FIFO_DEPTH (FIFO_DEPTH),
        .OVERSAMPLE (OVERSAMPLE)
    ) u_uart_core (
        .clk          (clk),
        .rst          (rst),
        .tx           (tx),
        .rx           (rx),
        .tx_en        (tx_en),
        .rx_mask      (rx_mask),
        .tx_push      (tx_push),
        .tx_data      (tx_data),
        .tx_full      (tx_full),
        .rx_pop       (rx_pop),
        .rx_data      (rx_data),
        .rx_empty     (rx_empty),
        .error_clear  (error_clear),
        .error_frame  (error_frame),
        .error_parity (error_parity)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // frames seen on the wire
    always @(negedge clk) begin
        tx_en_q <= tx_en;
        if (tx_en === 1'b1 && tx_en_q === 1'b0) begin
            tx_en_rises <= tx_en_rises + 1;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_byte(output logic [DATA-1:0] b);
        rng_state = xorshift32(rng_state);
        b = rng_state[DATA-1:0];
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            failures++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name,
                 (failures == failures_before) ? "ok" : "had errors");
        failures_before = failures;
    endtask

    task automatic push_bytes(input int n);
        logic [DATA-1:0] b;
        for (int i = 0; i < n; i++) begin
            while (tx_full) @(negedge clk);
            random_byte(b);
            tx_data = b;
            tx_push = 1'b1;
            expected.push_back(b);
            @(negedge clk);
            tx_push = 1'b0;
        end
    endtask

    task automatic receive_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            while (rx_empty) @(negedge clk);
            if (expected.size() == 0) begin
                expect_true(1'b0, "word received while none was expected");
            end else begin
                expect_true(rx_data == expected[0],
                            $sformatf("rx_data %02h, expected %02h", rx_data, expected[0]));
                void'(expected.pop_front());
            end
            rx_pop = 1'b1;
            @(negedge clk);
            rx_pop = 1'b0;
        end
    endtask

    // start, data lsb first, even parity, stop, then one idle bit
    task automatic send_frame(input logic [DATA-1:0] b, input logic bad_parity,
                              input logic bad_stop);
        logic [FRAME_BITS-1:0] bits;
        bits = {~bad_stop, (^b) ^ bad_parity, b, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            forced_rx = bits[i];
            repeat (OVERSAMPLE) @(negedge clk);
        end
        forced_rx = 1'b1;
        repeat (OVERSAMPLE) @(negedge clk);
    endtask

    task automatic clear_errors();
        error_clear = 1'b1;
        @(negedge clk);
        error_clear = 1'b0;
    endtask

    task automatic clear_on_report();
        while (!u_uart_core.rxi_valid) @(negedge clk);
        clear_errors();
    endtask

    initial begin
        logic [DATA-1:0] b;
        int              accepted;
        int              rises_before;
        int              prop_failures;
        rng_state   = 32'hab24_8719;
        rst         = 1'b1;
        rx_mask     = 1'b0;
        tx_push     = 1'b0;
        tx_data     = '0;
        rx_pop      = 1'b0;
        error_clear = 1'b0;
        loopback    = 1'b1;
        forced_rx   = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        fork
            push_bytes(12);
            receive_bytes(12);
        join
        expect_true(!error_frame && !error_parity, "error flag set during loopback");
        end_test("loopback order");

        while (tx_en) @(negedge clk);
        rises_before = tx_en_rises;
        accepted = 0;
        while (!tx_full) begin
            random_byte(b);
            tx_data = b;
            tx_push = 1'b1;
            expected.push_back(b);
            accepted++;
            @(negedge clk);
        end
        // this word arrives while full and is lost
        random_byte(b);
        tx_data = b;
        @(negedge clk);
        tx_push = 1'b0;
        expect_true(accepted >= FIFO_DEPTH,
                    $sformatf("only %0d words accepted before tx_full", accepted));
        expect_true(tx_en, "tx_en low while frames are queued");
        receive_bytes(accepted);
        while (tx_en) @(negedge clk);
        expect_true(tx_en_rises - rises_before == accepted,
                    $sformatf("%0d frames for %0d words", tx_en_rises - rises_before, accepted));
        repeat (OVERSAMPLE) @(negedge clk);
        expect_true(!tx_en && rx_empty, "activity after the last accepted word");
        end_test("buffering");

        loopback = 1'b0;
        random_byte(b);
        send_frame(b, 1'b1, 1'b0);
        expect_true(error_parity, "error_parity not set by a bad parity bit");
        expect_true(!error_frame, "error_frame set by a bad parity bit");
        expect_true(rx_empty, "word with a parity error was stored");
        random_byte(b);
        expected.push_back(b);
        send_frame(b, 1'b0, 1'b0);
        expect_true(!rx_empty, "good frame after a parity error not received");
        receive_bytes(1);
        clear_errors();
        expect_true(!error_parity, "error_parity still set after error_clear");
        end_test("parity error");

        random_byte(b);
        send_frame(b, 1'b0, 1'b1);
        expect_true(error_frame, "error_frame not set by a low stop bit");
        expect_true(!error_parity, "error_parity set by a low stop bit");
        expect_true(rx_empty, "word with a frame error was stored");
        clear_errors();
        expect_true(!error_frame, "error_frame still set after error_clear");
        random_byte(b);
        fork
            send_frame(b, 1'b0, 1'b1);
            clear_on_report();
        join
        expect_true(error_frame, "clear in the report cycle lowered error_frame");
        clear_errors();
        end_test("frame error and clear");

        rx_mask = 1'b1;
        random_byte(b);
        send_frame(b, 1'b0, 1'b0);
        random_byte(b);
        send_frame(b, 1'b1, 1'b0);
        expect_true(rx_empty, "masked frame produced data");
        expect_true(!error_frame && !error_parity, "masked frame raised a flag");
        rx_mask = 1'b0;
        end_test("receive mask");

        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            random_byte(b);
            if (i < FIFO_DEPTH) begin
                expected.push_back(b);
            end
            send_frame(b, 1'b0, 1'b0);
        end
        receive_bytes(FIFO_DEPTH);
        @(negedge clk);
        expect_true(rx_empty, "more than FIFO_DEPTH words were stored");
        end_test("receive overflow");

        prop_failures = u_uart_core.u_uart_core_properties.assert_failures;
        $display("tests: %0d, checks: %0d, check failures: %0d, property failures: %0d",
                 tests, checks, failures, prop_failures);
        if (failures == 0 && prop_failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/uart_pkg.sv
logic/baud_tick_gen.sv
logic/sync_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
uart_core/uart_core.sv
tb/uart_core_properties.sv
tb/tb_uart_core.sv
